/* vlog.f */
logic/hc_pkg.sv
logic/hc_csr.sv
logic/hc_scoreboard.sv
logic/hc_fifo2.sv
logic/hc_fifo_from_host.sv
logic/hc_host_reader_top.sv
sim/hc_mem_model.sv
sim/hc_host_reader_chk.sv
sim/tb_hc_host_reader.sv

/* sim/tb_hc_host_reader.sv */
// ================================================
// Testbench for the host ring-buffer reader
// Runs a table of ring scenarios against a random
// out of order memory and checks data, addresses,
// tags and the register readback
// ================================================

`default_nettype none

module tb_hc_host_reader;

    import hc_pkg::*;

    localparam logic [31:0] SEED = 32'h9107_e1bf;
    localparam int N_SCEN        = 5;
    localparam int RESET_CYCLES  = 3;
    localparam int MAX_IN_FLIGHT = ROB_ENTRIES + 2;
    localparam int HOLD_CYCLES   = 300;
    localparam int IDLE_CYCLES   = 40;
    localparam int AHEAD_LINES   = 200;

    // Consumer stall patterns
    localparam int STALL_NONE   = 0;
    localparam int STALL_RANDOM = 1;
    localparam int STALL_HOLD   = 2;

    logic       clk;
    logic       reset_n;
    logic       csr_wr_en;
    csr_sel_t   csr_sel;
    line_addr_t csr_wdata;
    line_addr_t csr_rdata;
    logic       rd_req;
    line_addr_t rd_addr;
    rob_tag_t   rd_tag;
    logic       rd_grant;
    logic       rsp_valid;
    rob_tag_t   rsp_tag;
    line_data_t rsp_data;
    logic       out_valid;
    line_data_t out_data;
    logic       out_enable;
    ring_idx_t  oldest_idx;

    // Scenario table, one column per field
    line_addr_t tbl_base    [N_SCEN];
    int         tbl_publish [N_SCEN];
    int         tbl_stall   [N_SCEN];
    int         tbl_consume [N_SCEN];

    // Reference state kept by the testbench
    line_addr_t  cur_base;
    ring_idx_t   deliv_pos;
    ring_idx_t   issue_pos;
    int          delivered_total;
    int          published_total;
    int          mon_issued;
    int          mon_delivered;
    int unsigned run_cycles;
    int unsigned timeout_limit;

    hc_host_reader_top u_dut
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .csr_wr_en  (csr_wr_en),
        .csr_sel    (csr_sel),
        .csr_wdata  (csr_wdata),
        .csr_rdata  (csr_rdata),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_tag     (rd_tag),
        .rd_grant   (rd_grant),
        .rsp_valid  (rsp_valid),
        .rsp_tag    (rsp_tag),
        .rsp_data   (rsp_data),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_enable (out_enable),
        .oldest_idx (oldest_idx)
    );

    hc_mem_model u_mem
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_tag    (rd_tag),
        .rd_grant  (rd_grant),
        .rsp_valid (rsp_valid),
        .rsp_tag   (rsp_tag),
        .rsp_data  (rsp_data)
    );

    // ================================================
    // Reporting and compare tasks
    // ================================================

    task automatic stop_run;
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_line(input line_data_t got, input line_data_t exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_idx(input ring_idx_t got, input ring_idx_t exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input line_addr_t got, input line_addr_t exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_tag(input rob_tag_t got, input rob_tag_t exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    // The host writes each line as its address over the inverted address
    function automatic line_data_t predict_line(input line_addr_t base, input ring_idx_t idx);
        line_addr_t addr;
        addr = base + line_addr_t'(idx);
        return {addr, ~addr};
    endfunction

    function automatic logic consumer_enable(input int mode, input int cyc);
        case (mode)
            STALL_NONE:   return 1'b1;
            STALL_RANDOM: return (($urandom % 2) == 0);
            default:      return (cyc >= HOLD_CYCLES);
        endcase
    endfunction

    // ================================================
    // Scenario table
    // ================================================

    // Row 1 crosses the ring wrap, row 2 wraps the address and stalls,
    // row 3 publishes nothing at all
    task automatic load_table;
        tbl_base    = '{32'h0000_1000, 32'h0001_2345, 32'hFFFF_FF80, 32'h0000_0007, 32'h0ABC_DEF1};
        tbl_publish = '{40, 300, 60, 0, 80};
        tbl_stall   = '{STALL_NONE, STALL_RANDOM, STALL_HOLD, STALL_NONE, STALL_RANDOM};
        tbl_consume = '{40, 300, 60, 0, 80};
    endtask

    function automatic int table_lines;
        int sum;
        sum = 0;
        for (int s = 0; s < N_SCEN; s++)
        begin
            sum += tbl_publish[s];
        end
        return sum;
    endfunction

    task automatic write_csr(input csr_sel_t sel, input line_addr_t value);
        csr_wr_en <= 1'b1;
        csr_sel   <= sel;
        csr_wdata <= value;
        @(posedge clk);
        csr_wr_en <= 1'b0;
    endtask

    task automatic run_scenario(input int s);
        int        pub_s;
        int        del_s;
        int        cyc;
        int        target;
        ring_idx_t start_pos;

        pub_s     = 0;
        del_s     = 0;
        cyc       = 0;
        start_pos = deliv_pos;
        cur_base  = tbl_base[s];
        write_csr(CSR_BASE_ADDR, tbl_base[s]);

        while (del_s < tbl_consume[s])
        begin
            @(posedge clk);
            cyc++;

            // A line is taken on an edge where valid and enable were both high
            if (out_valid && out_enable)
            begin
                check_line(out_data, predict_line(cur_base, deliv_pos), "out_data");
                deliv_pos++;
                del_s++;
                delivered_total++;
            end

            // Keep the published window well below the ring size
            target = del_s + AHEAD_LINES;
            if (target > tbl_publish[s])
                target = tbl_publish[s];

            if (target > pub_s && (target == tbl_publish[s] || target - pub_s >= 32))
            begin
                published_total += target - pub_s;
                pub_s = target;
                csr_wr_en <= 1'b1;
                csr_sel   <= CSR_NEWEST_IDX;
                csr_wdata <= line_addr_t'(ring_idx_t'(start_pos + pub_s));
            end
            else
            begin
                csr_wr_en <= 1'b0;
            end

            out_enable <= consumer_enable(tbl_stall[s], cyc);
        end

        // With everything delivered the reader must go quiet
        csr_wr_en  <= 1'b0;
        out_enable <= 1'b1;
        repeat (IDLE_CYCLES)
        begin
            @(posedge clk);
            if (out_valid)
                report_failure("a line was delivered beyond the published lines");
            if (rd_req)
                report_failure("a read was requested with no new line published");
        end

        csr_sel <= CSR_OLDEST_IDX;
        @(posedge clk);
        check_addr(csr_rdata, line_addr_t'(ring_idx_t'(delivered_total)), "oldest readback");
        check_idx(oldest_idx, ring_idx_t'(delivered_total), "oldest_idx port");
        csr_sel <= CSR_BASE_ADDR;
        @(posedge clk);
        check_addr(csr_rdata, tbl_base[s], "base readback");
    endtask

    // ================================================
    // Clock, monitors and timeout
    // ================================================

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    // Every accepted request must point at base plus its ring index
    always @(posedge clk)
    begin
        if (reset_n)
        begin
            if (out_valid && out_enable)
                mon_delivered++;
            if (rd_grant)
            begin
                check_addr(rd_addr, cur_base + line_addr_t'(issue_pos), "rd_addr");
                // Slots are handed out in order from zero, one per accepted read
                check_tag(rd_tag, rob_tag_t'(mon_issued), "rd_tag");
                issue_pos++;
                mon_issued++;
                if (mon_issued > published_total)
                    report_failure("a read was issued beyond the published lines");
            end
            // Sixteen slots plus two buffer entries bound the lines in flight
            if (mon_issued - mon_delivered > MAX_IN_FLIGHT)
                report_failure("more lines in flight than the reader can hold");
        end
    end

    always @(posedge clk)
    begin
        run_cycles++;
        if (timeout_limit != 0 && run_cycles > timeout_limit)
            report_failure("the run did not finish within its cycle limit");
        if (u_dut.u_reader.u_chk.assert_failed)
            report_failure("a protocol assertion in the ring reader failed");
    end

    // ================================================
    // Main sequence
    // ================================================

    initial
    begin
        void'($urandom(SEED));
        reset_n         = 1'b0;
        csr_wr_en       = 1'b0;
        csr_sel         = CSR_BASE_ADDR;
        csr_wdata       = '0;
        out_enable      = 1'b0;
        cur_base        = '0;
        deliv_pos       = '0;
        issue_pos       = '0;
        delivered_total = 0;
        published_total = 0;
        mon_issued      = 0;
        mon_delivered   = 0;
        run_cycles      = 0;
        load_table();
        timeout_limit = 40 * table_lines() + 2000;

        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);

        for (int s = 0; s < N_SCEN; s++)
        begin
            run_scenario(s);
        end

        if (!u_dut.u_reader.u_chk.assert_failed)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/hc_host_reader_chk.sv */
// ================================================
// Protocol assertions for the ring reader
// Bound into every ring reader instance
// ================================================

`default_nettype none

module hc_host_reader_chk
(
    input wire logic               clk,
    input wire logic               reset_n,
    input wire logic               rd_req,
    input wire logic               rd_grant,
    input wire logic               out_valid,
    input wire logic               out_enable,
    input wire hc_pkg::line_data_t out_data
);

    // Set once any rule below has been broken
    logic assert_failed = 1'b0;

    // Memory may only accept a request that is being made
    a_grant_with_req: assert property (@(posedge clk) disable iff (!reset_n)
        rd_grant |-> rd_req)
        else
        begin
            $error("read grant seen while no read was requested");
            assert_failed = 1'b1;
        end

    // Once the first reset edge has passed, no read goes out until reset ends
    a_no_req_in_reset: assert property (@(posedge clk)
        (!reset_n ##1 !reset_n) |-> !rd_req)
        else
        begin
            $error("read requested while reset is held");
            assert_failed = 1'b1;
        end

    // A line waiting for the consumer must not change under it
    a_data_held: assert property (@(posedge clk) disable iff (!reset_n)
        (out_valid && !out_enable) |=> $stable(out_data))
        else
        begin
            $error("output line changed while the consumer was stalled");
            assert_failed = 1'b1;
        end

endmodule

bind hc_fifo_from_host hc_host_reader_chk u_chk
(
    .clk        (clk),
    .reset_n    (reset_n),
    .rd_req     (rd_req),
    .rd_grant   (rd_grant),
    .out_valid  (out_valid),
    .out_enable (out_enable),
    .out_data   (out_data)
);

`default_nettype wire

/* sim/hc_mem_model.sv */
// ================================================
// Host memory model for the ring reader testbench
// Grants read requests at random and answers each
// tag once after a random delay, out of order
// ================================================

`default_nettype none

module hc_mem_model
(
    input  wire logic               clk,
    input  wire logic               reset_n,
    input  wire logic               rd_req,
    input  wire hc_pkg::line_addr_t rd_addr,
    input  wire hc_pkg::rob_tag_t   rd_tag,
    output logic                    rd_grant,
    output logic                    rsp_valid,
    output hc_pkg::rob_tag_t        rsp_tag,
    output hc_pkg::line_data_t      rsp_data
);

    import hc_pkg::*;

    // Longest response delay in cycles
    localparam int MAX_DELAY = 20;

    // Registered coin toss, so the grant only follows a request that is up
    logic grant_roll;

    // One pending response per tag, as each tag is in flight at most once
    logic        pend_valid [ROB_ENTRIES];
    line_addr_t  pend_addr  [ROB_ENTRIES];
    int unsigned pend_due   [ROB_ENTRIES];
    int unsigned cycle_cnt;

    assign rd_grant = rd_req && grant_roll;

    initial
    begin
        grant_roll = 1'b0;
        rsp_valid  = 1'b0;
        rsp_tag    = '0;
        rsp_data   = '0;
        cycle_cnt  = 0;
        for (int i = 0; i < ROB_ENTRIES; i++)
        begin
            pend_valid[i] = 1'b0;
        end
    end

    always @(posedge clk)
    begin : serve
        int pick;
        int start;
        int slot;

        if (!reset_n)
        begin
            grant_roll <= 1'b0;
            rsp_valid  <= 1'b0;
            cycle_cnt = 0;
            for (int i = 0; i < ROB_ENTRIES; i++)
            begin
                pend_valid[i] = 1'b0;
            end
        end
        else
        begin
            cycle_cnt = cycle_cnt + 1;

            // Pick one due response, searching from a random slot so the
            // order of return does not follow the order of issue
            pick  = -1;
            start = $urandom % ROB_ENTRIES;
            for (int k = 0; k < ROB_ENTRIES; k++)
            begin
                slot = (start + k) % ROB_ENTRIES;
                if (pick < 0 && pend_valid[slot] && pend_due[slot] <= cycle_cnt)
                begin
                    pick = slot;
                end
            end

            if (pick >= 0)
            begin
                // Address in the upper half, its inverse in the lower half
                rsp_valid <= 1'b1;
                rsp_tag   <= rob_tag_t'(pick);
                rsp_data  <= {pend_addr[pick], ~pend_addr[pick]};
                pend_valid[pick] = 1'b0;
            end
            else
            begin
                rsp_valid <= 1'b0;
            end

            // The request seen with a grant at this edge is accepted
            if (rd_grant)
            begin
                pend_valid[rd_tag] = 1'b1;
                pend_addr[rd_tag]  = rd_addr;
                pend_due[rd_tag]   = cycle_cnt + 1 + ($urandom % MAX_DELAY);
            end

            // Grant about three cycles in four
            grant_roll <= (($urandom % 4) != 0);
        end
    end

endmodule

`default_nettype wire

/* logic/hc_host_reader_top.sv */
// ================================================
// Top level of the host ring-buffer reader
// Joins the register block and the ring reader
// ================================================

`default_nettype none

module hc_host_reader_top
(
    input  wire logic               clk,
    input  wire logic               reset_n,
    // Register port
    input  wire logic               csr_wr_en,
    input  wire hc_pkg::csr_sel_t   csr_sel,
    input  wire hc_pkg::line_addr_t csr_wdata,
    output hc_pkg::line_addr_t      csr_rdata,
    // Memory request and response
    output logic                    rd_req,
    output hc_pkg::line_addr_t      rd_addr,
    output hc_pkg::rob_tag_t        rd_tag,
    input  wire logic               rd_grant,
    input  wire logic               rsp_valid,
    input  wire hc_pkg::rob_tag_t   rsp_tag,
    input  wire hc_pkg::line_data_t rsp_data,
    // Consumer
    output logic                    out_valid,
    output hc_pkg::line_data_t      out_data,
    input  wire logic               out_enable,
    // Status
    output hc_pkg::ring_idx_t       oldest_idx
);

    import hc_pkg::*;

    // Register values that steer the reader
    line_addr_t base_addr;
    ring_idx_t  newest_idx;

    hc_csr u_csr
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .csr_wr_en  (csr_wr_en),
        .csr_sel    (csr_sel),
        .csr_wdata  (csr_wdata),
        .oldest_idx (oldest_idx),
        .csr_rdata  (csr_rdata),
        .base_addr  (base_addr),
        .newest_idx (newest_idx)
    );

    hc_fifo_from_host u_reader
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .base_addr  (base_addr),
        .newest_idx (newest_idx),
        .rd_grant   (rd_grant),
        .rsp_valid  (rsp_valid),
        .rsp_tag    (rsp_tag),
        .rsp_data   (rsp_data),
        .out_enable (out_enable),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_tag     (rd_tag),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .oldest_idx (oldest_idx)
    );

endmodule

`default_nettype wire

/* logic/hc_fifo_from_host.sv */
// ================================================
// Ring-buffer reader from host memory
// Issues line reads as the host publishes data,
// sorts the tagged responses back into ring order
// and hands them to the consumer
// ================================================

`default_nettype none

module hc_fifo_from_host
(
    input  wire logic               clk,
    input  wire logic               reset_n,
    input  wire hc_pkg::line_addr_t base_addr,
    input  wire hc_pkg::ring_idx_t  newest_idx,
    input  wire logic               rd_grant,
    input  wire logic               rsp_valid,
    input  wire hc_pkg::rob_tag_t   rsp_tag,
    input  wire hc_pkg::line_data_t rsp_data,
    input  wire logic               out_enable,
    output logic                    rd_req,
    output hc_pkg::line_addr_t      rd_addr,
    output hc_pkg::rob_tag_t        rd_tag,
    output logic                    out_valid,
    output hc_pkg::line_data_t      out_data,
    output hc_pkg::ring_idx_t       oldest_idx
);

    import hc_pkg::*;

    // Ring index of the next line to request
    ring_idx_t next_idx;

    // Scoreboard side
    logic       slot_rdy;
    rob_tag_t   alloc_tag;
    logic       head_valid;
    line_data_t head_data;
    logic       alloc_en;
    logic       release_en;

    // Output queue side
    logic fifo_not_full;

    // ================================================
    // Read requests
    // ================================================

    // Ask for a line while the host has published more than was requested
    // and a reorder slot is free to receive it
    assign rd_req = (next_idx != newest_idx) && slot_rdy;

    // The address is formed by adding, so the ring base needs no alignment
    // Wrap still relies on the ring size being a power of two
    assign rd_addr = base_addr + line_addr_t'(next_idx);

    // The tag is the slot that the grant will claim
    assign rd_tag   = alloc_tag;
    assign alloc_en = rd_grant;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            next_idx <= '0;
        end
        else if (rd_grant)
        begin
            // The request was taken, so move on to the next line
            next_idx <= next_idx + 1'b1;
        end
    end

    // ================================================
    // Reorder and release
    // ================================================

    hc_scoreboard u_scoreboard
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .alloc_en   (alloc_en),
        .fill_en    (rsp_valid),
        .fill_tag   (rsp_tag),
        .fill_data  (rsp_data),
        .release_en (release_en),
        .slot_rdy   (slot_rdy),
        .alloc_tag  (alloc_tag),
        .head_valid (head_valid),
        .head_data  (head_data)
    );

    // Move the head line on when it has arrived and the queue has room
    assign release_en = head_valid && fifo_not_full;

    // The oldest index follows lines as they leave the scoreboard
    // It tells the host which ring lines may be overwritten
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            oldest_idx <= '0;
        end
        else if (release_en)
        begin
            oldest_idx <= oldest_idx + 1'b1;
        end
    end

    hc_fifo2 u_out_fifo
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .enq_en    (release_en),
        .enq_data  (head_data),
        .deq_en    (out_enable),
        .not_full  (fifo_not_full),
        .not_empty (out_valid),
        .first     (out_data)
    );

endmodule

`default_nettype wire

/* logic/hc_fifo2.sv */
// ================================================
// Two-entry output queue toward the consumer
// Registers the line stream so that the consumer
// sees no path back into the scoreboard
// ================================================

`default_nettype none

module hc_fifo2
(
    input  wire logic               clk,
    input  wire logic               reset_n,
    input  wire logic               enq_en,
    input  wire hc_pkg::line_data_t enq_data,
    input  wire logic               deq_en,
    output logic                    not_full,
    output logic                    not_empty,
    output hc_pkg::line_data_t      first
);

    import hc_pkg::*;

    // Entry 0 is always the head, entry 1 waits behind it
    logic       valid0;
    logic       valid1;
    line_data_t data0;
    line_data_t data1;

    // Requests are only honoured when the queue can take them
    logic enq_ok;
    logic deq_ok;

    assign enq_ok = enq_en && !valid1;
    assign deq_ok = deq_en && valid0;

    // A new line goes to the head when the head is free or leaving now
    logic enq_to_head;
    assign enq_to_head = !valid0 || deq_ok;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            valid0 <= 1'b0;
            valid1 <= 1'b0;
        end
        else
        begin
            // A dequeue shifts the second entry forward
            if (deq_ok)
            begin
                valid0 <= valid1;
                valid1 <= 1'b0;
            end

            if (enq_ok)
            begin
                if (enq_to_head)
                    valid0 <= 1'b1;
                else
                    valid1 <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (deq_ok)
        begin
            data0 <= data1;
        end

        if (enq_ok)
        begin
            if (enq_to_head)
                data0 <= enq_data;
            else
                data1 <= enq_data;
        end
    end

    assign not_full  = !valid1;
    assign not_empty = valid0;
    assign first     = data0;

endmodule

`default_nettype wire

/* logic/hc_scoreboard.sv */
// ================================================
// Reorder scoreboard for ring line reads
// Hands out tags in order, takes responses by tag
// in any order and releases lines in tag order
// ================================================

`default_nettype none

module hc_scoreboard
(
    input  wire logic               clk,
    input  wire logic               reset_n,
    input  wire logic               alloc_en,
    input  wire logic               fill_en,
    input  wire hc_pkg::rob_tag_t   fill_tag,
    input  wire hc_pkg::line_data_t fill_data,
    input  wire logic               release_en,
    output logic                    slot_rdy,
    output hc_pkg::rob_tag_t        alloc_tag,
    output logic                    head_valid,
    output hc_pkg::line_data_t      head_data
);

    import hc_pkg::*;

    // Next slot to hand out, which is also the tag of the next request
    rob_tag_t alloc_ptr;

    // Oldest allocated slot, the one that must leave first
    rob_tag_t rel_ptr;

    // Number of allocated slots, one bit wider than a tag so that full is visible
    logic [ROB_TAG_BITS:0] used_cnt;

    // One bit per slot, set when the response for that slot has arrived
    logic [ROB_ENTRIES-1:0] filled;

    // Response payload, indexed by tag
    line_data_t slot_data [ROB_ENTRIES];

    // ================================================
    // Allocation and release pointers
    // ================================================

    assign slot_rdy  = (used_cnt != (ROB_TAG_BITS + 1)'(ROB_ENTRIES));
    assign alloc_tag = alloc_ptr;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            alloc_ptr <= '0;
            rel_ptr   <= '0;
            used_cnt  <= '0;
        end
        else
        begin
            // Both pointers wrap naturally at the slot count
            if (alloc_en)
            begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end

            if (release_en)
            begin
                rel_ptr <= rel_ptr + 1'b1;
            end

            // An allocation and a release in the same cycle cancel out
            case ({alloc_en, release_en})
                2'b10:   used_cnt <= used_cnt + 1'b1;
                2'b01:   used_cnt <= used_cnt - 1'b1;
                default: used_cnt <= used_cnt;
            endcase
        end
    end

    // ================================================
    // Fill tracking and payload
    // ================================================

    // A fill and a release never touch the same slot in one cycle,
    // because a slot must already be filled before it can leave
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            filled <= '0;
        end
        else
        begin
            if (release_en)
            begin
                filled[rel_ptr] <= 1'b0;
            end

            if (fill_en)
            begin
                filled[fill_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            slot_data[fill_tag] <= fill_data;
        end
    end

    // The head is ready once the oldest request has its response
    // Later slots may already be filled, but they wait their turn
    assign head_valid = filled[rel_ptr];
    assign head_data  = slot_data[rel_ptr];

endmodule

`default_nettype wire

/* logic/hc_csr.sv */
// ================================================
// Register block beside the ring reader
// Holds the ring base address and the newest index
// written by the host, and reads back the oldest
// index that the reader has released
// ================================================

`default_nettype none

module hc_csr
(
    input  wire logic               clk,
    input  wire logic               reset_n,
    input  wire logic               csr_wr_en,
    input  wire hc_pkg::csr_sel_t   csr_sel,
    input  wire hc_pkg::line_addr_t csr_wdata,
    input  wire hc_pkg::ring_idx_t  oldest_idx,
    output hc_pkg::line_addr_t      csr_rdata,
    output hc_pkg::line_addr_t      base_addr,
    output hc_pkg::ring_idx_t       newest_idx
);

    import hc_pkg::*;

    // Host writes land on the next edge and go straight to the reader
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            base_addr  <= '0;
            newest_idx <= '0;
        end
        else if (csr_wr_en)
        begin
            case (csr_sel)
                CSR_BASE_ADDR:
                begin
                    base_addr <= csr_wdata;
                end
                CSR_NEWEST_IDX:
                begin
                    // Only the low bits form a ring index
                    newest_idx <= ring_idx_t'(csr_wdata);
                end
                default:
                begin
                    // The oldest index is read only, writes to it are dropped
                end
            endcase
        end
    end

    // Readback is combinational from the select
    // Indices are zero extended to the register width
    always_comb
    begin
        case (csr_sel)
            CSR_BASE_ADDR:  csr_rdata = base_addr;
            CSR_NEWEST_IDX: csr_rdata = line_addr_t'(newest_idx);
            CSR_OLDEST_IDX: csr_rdata = line_addr_t'(oldest_idx);
            default:        csr_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/hc_pkg.sv */
// ================================================
// Shared definitions for the host ring-buffer reader
// Widths, ring and scoreboard sizes, vector types
// and the register map
// ================================================

`default_nettype none

package hc_pkg;

    // ================================================
    // Widths and sizes
    // ================================================

    // One ring line as the host writes it
    localparam int LINE_BITS = 64;

    // Host addresses are counted in lines and not in bytes
    localparam int ADDR_BITS = 32;

    // The ring holds 256 lines, so an index wraps by itself
    localparam int RING_IDX_BITS = 8;

    // Reorder slots, one per read that may be in flight
    localparam int ROB_ENTRIES  = 16;
    localparam int ROB_TAG_BITS = 4;

    // Register select width on the register port
    localparam int CSR_SEL_BITS = 2;

    // ================================================
    // Vector types
    // ================================================

    typedef logic [LINE_BITS-1:0]     line_data_t;
    typedef logic [ADDR_BITS-1:0]     line_addr_t;
    typedef logic [RING_IDX_BITS-1:0] ring_idx_t;
    typedef logic [ROB_TAG_BITS-1:0]  rob_tag_t;
    typedef logic [CSR_SEL_BITS-1:0]  csr_sel_t;

    // Register map
    localparam csr_sel_t CSR_BASE_ADDR  = 2'd0;
    localparam csr_sel_t CSR_NEWEST_IDX = 2'd1;
    localparam csr_sel_t CSR_OLDEST_IDX = 2'd2;

endpackage

`default_nettype wire
